//--- dzcpu_defines.svh
`ifndef DZCPU_DEFINES_SVH
`define DZCPU_DEFINES_SVH

// Address of the first opcode after reset
`define DZ_PC_RESET 16'h0000

//////////////////////////////////////////////////
// Micro-op field widths
//////////////////////////////////////////////////
`define DZ_UPC_W 8
`define DZ_SEQ_W 4
`define DZ_CMD_W 4
`define DZ_OPND_W 5

//////////////////////////////////////////////////
// Kept opcodes, Game Boy encodings
//////////////////////////////////////////////////
`define OP_NOP     8'h00
`define OP_LDB_N   8'h06
`define OP_LDC_N   8'h0E
`define OP_LDD_N   8'h16
`define OP_LDE_N   8'h1E
`define OP_LDH_N   8'h26
`define OP_LDL_N   8'h2E
`define OP_LDA_N   8'h3E
`define OP_LDHL_NN 8'h21
`define OP_INC_B   8'h04
`define OP_INC_C   8'h0C
`define OP_INC_D   8'h14
`define OP_INC_E   8'h1C
`define OP_INC_H   8'h24
`define OP_INC_L   8'h2C
`define OP_INC_A   8'h3C
`define OP_DEC_B   8'h05
`define OP_DEC_C   8'h0D
`define OP_DEC_D   8'h15
`define OP_DEC_E   8'h1D
`define OP_DEC_H   8'h25
`define OP_DEC_L   8'h2D
`define OP_DEC_A   8'h3D
`define OP_ADD_A_A 8'h87
`define OP_ADD_A_B 8'h80
`define OP_SUB_B   8'h90
`define OP_CP_N    8'hFE
`define OP_LD_HL_A 8'h77
`define OP_LD_HLI_A 8'h22
`define OP_JR_N    8'h18
`define OP_JR_NZ   8'h20
`define OP_JR_Z    8'h28

`endif

//--- dzcpu_pkg.sv
`include "dzcpu_defines.svh"

package dzcpu_pkg;

	//////////////////////////////////////////////////
	// Micro-op fields
	//////////////////////////////////////////////////

	// Sequencing field, what happens after this micro-op
	typedef enum logic [`DZ_SEQ_W-1:0] {
		seqOp, seqInc, seqEof, seqIncEof, seqIncEofZ, seqIncEofNz,
		seqEofFu, seqIncEofFu, seqUpdateFlags
	} seqCmd_t;

	// Operation field
	typedef enum logic [`DZ_CMD_W-1:0] {
		cmdNop, cmdSma, cmdSmw, cmdSrm, cmdInc16, cmdDec16,
		cmdSx16r, cmdSrx16, cmdAddx16, cmdSubx16, cmdSpc
	} uopCmd_t;

	// Operand field; A to L double as register file index
	typedef enum logic [`DZ_OPND_W-1:0] {
		regA, regB, regC, regD, regE, regH, regL,
		regHl, regDe, regPc, regX8, regX16, regNull
	} operand_t;

	typedef struct packed {
		seqCmd_t  seq;
		uopCmd_t  cmd;
		operand_t operand;
	} uop_t;

	// Idle micro-op, also the value of unused ROM slots
	localparam uop_t uopIdle = '{seq: seqOp, cmd: cmdNop, operand: regNull};

	//////////////////////////////////////////////////
	// Memory bus payloads
	//////////////////////////////////////////////////
	typedef struct packed {
		logic [15:0] addr;
	} memReq_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
	} memWrite_t;

	typedef struct packed {
		logic [7:0] data;
	} memRead_t;

	// Unconditional end of flow
	function automatic logic isEof(seqCmd_t seq);
		return seq inside {seqEof, seqIncEof, seqEofFu, seqIncEofFu};
	endfunction

	// Codes that step the PC
	function automatic logic incsPc(seqCmd_t seq);
		return seq inside {seqInc, seqIncEof, seqIncEofZ, seqIncEofNz, seqIncEofFu};
	endfunction

endpackage

//--- dzcpu_ucode_lut.sv
`timescale 1ns/10ps
`include "dzcpu_defines.svh"

module dzcpu_ucode_lut
(
	input  logic [7:0] opcode,
	output logic [7:0] flowStart
);

	// Opcode to first ROM address of its flow
	always_comb
	begin
		case (opcode)
			`OP_LDB_N:    flowStart = 8'd1;
			`OP_LDC_N:    flowStart = 8'd4;
			`OP_LDD_N:    flowStart = 8'd7;
			`OP_LDE_N:    flowStart = 8'd10;
			`OP_LDH_N:    flowStart = 8'd13;
			`OP_LDL_N:    flowStart = 8'd16;
			`OP_LDA_N:    flowStart = 8'd19;
			`OP_LDHL_NN:  flowStart = 8'd22;
			`OP_INC_B:    flowStart = 8'd27;
			`OP_INC_C:    flowStart = 8'd28;
			`OP_INC_D:    flowStart = 8'd29;
			`OP_INC_E:    flowStart = 8'd30;
			`OP_INC_H:    flowStart = 8'd31;
			`OP_INC_L:    flowStart = 8'd32;
			`OP_INC_A:    flowStart = 8'd33;
			`OP_DEC_B:    flowStart = 8'd34;
			`OP_DEC_C:    flowStart = 8'd35;
			`OP_DEC_D:    flowStart = 8'd36;
			`OP_DEC_E:    flowStart = 8'd37;
			`OP_DEC_H:    flowStart = 8'd38;
			`OP_DEC_L:    flowStart = 8'd39;
			`OP_DEC_A:    flowStart = 8'd40;
			`OP_ADD_A_A:  flowStart = 8'd41;
			`OP_ADD_A_B:  flowStart = 8'd44;
			`OP_SUB_B:    flowStart = 8'd47;
			`OP_CP_N:     flowStart = 8'd50;
			`OP_LD_HL_A:  flowStart = 8'd55;
			`OP_LD_HLI_A: flowStart = 8'd57;
			`OP_JR_N:     flowStart = 8'd60;
			`OP_JR_NZ:    flowStart = 8'd66;
			`OP_JR_Z:     flowStart = 8'd72;
			// NOP and anything unknown
			default:      flowStart = 8'd0;
		endcase
	end

endmodule

//--- dzcpu_ucode_rom.sv
`timescale 1ns/10ps
`include "dzcpu_defines.svh"

module dzcpu_ucode_rom
	import dzcpu_pkg::*;
(
	input  logic [`DZ_UPC_W-1:0] upc,
	output uop_t                 uop
);

	// Flow table; PC sits on the opcode when a flow starts
	function automatic uop_t romLookup(logic [`DZ_UPC_W-1:0] addr);
		case (addr)
			// NOP
			0:  return '{seqIncEof, cmdNop, regNull};
			// LD B,n: step past opcode, address the literal, read it
			1:  return '{seqInc, cmdNop, regNull};
			2:  return '{seqOp, cmdSma, regPc};
			3:  return '{seqIncEof, cmdSrm, regB};
			// LD C,n
			4:  return '{seqInc, cmdNop, regNull};
			5:  return '{seqOp, cmdSma, regPc};
			6:  return '{seqIncEof, cmdSrm, regC};
			// LD D,n
			7:  return '{seqInc, cmdNop, regNull};
			8:  return '{seqOp, cmdSma, regPc};
			9:  return '{seqIncEof, cmdSrm, regD};
			// LD E,n
			10: return '{seqInc, cmdNop, regNull};
			11: return '{seqOp, cmdSma, regPc};
			12: return '{seqIncEof, cmdSrm, regE};
			// LD H,n
			13: return '{seqInc, cmdNop, regNull};
			14: return '{seqOp, cmdSma, regPc};
			15: return '{seqIncEof, cmdSrm, regH};
			// LD L,n
			16: return '{seqInc, cmdNop, regNull};
			17: return '{seqOp, cmdSma, regPc};
			18: return '{seqIncEof, cmdSrm, regL};
			// LD A,n
			19: return '{seqInc, cmdNop, regNull};
			20: return '{seqOp, cmdSma, regPc};
			21: return '{seqIncEof, cmdSrm, regA};
			// LD HL,nn, low byte first
			22: return '{seqInc, cmdNop, regNull};
			23: return '{seqOp, cmdSma, regPc};
			24: return '{seqInc, cmdSrm, regL};
			25: return '{seqOp, cmdSma, regPc};
			26: return '{seqIncEof, cmdSrm, regH};
			// INC r
			27: return '{seqIncEofFu, cmdInc16, regB};
			28: return '{seqIncEofFu, cmdInc16, regC};
			29: return '{seqIncEofFu, cmdInc16, regD};
			30: return '{seqIncEofFu, cmdInc16, regE};
			31: return '{seqIncEofFu, cmdInc16, regH};
			32: return '{seqIncEofFu, cmdInc16, regL};
			33: return '{seqIncEofFu, cmdInc16, regA};
			// DEC r
			34: return '{seqIncEofFu, cmdDec16, regB};
			35: return '{seqIncEofFu, cmdDec16, regC};
			36: return '{seqIncEofFu, cmdDec16, regD};
			37: return '{seqIncEofFu, cmdDec16, regE};
			38: return '{seqIncEofFu, cmdDec16, regH};
			39: return '{seqIncEofFu, cmdDec16, regL};
			40: return '{seqIncEofFu, cmdDec16, regA};
			// ADD A,A through x16
			41: return '{seqOp, cmdSx16r, regA};
			42: return '{seqUpdateFlags, cmdAddx16, regA};
			43: return '{seqIncEof, cmdSrx16, regA};
			// ADD A,B
			44: return '{seqOp, cmdSx16r, regA};
			45: return '{seqUpdateFlags, cmdAddx16, regB};
			46: return '{seqIncEof, cmdSrx16, regA};
			// SUB B
			47: return '{seqOp, cmdSx16r, regA};
			48: return '{seqUpdateFlags, cmdSubx16, regB};
			49: return '{seqIncEof, cmdSrx16, regA};
			// CP n, result stays in x16 and A is untouched
			50: return '{seqInc, cmdNop, regNull};
			51: return '{seqOp, cmdSma, regPc};
			52: return '{seqInc, cmdSrm, regX8};
			53: return '{seqOp, cmdSx16r, regA};
			54: return '{seqEofFu, cmdSubx16, regX8};
			// LD (HL),A
			55: return '{seqOp, cmdSma, regHl};
			56: return '{seqIncEof, cmdSmw, regA};
			// LD (HL+),A, pair step keeps flags
			57: return '{seqOp, cmdSma, regHl};
			58: return '{seqOp, cmdSmw, regA};
			59: return '{seqIncEof, cmdInc16, regHl};
			// JR n, offset relative to the next opcode
			60: return '{seqInc, cmdNop, regNull};
			61: return '{seqOp, cmdSma, regPc};
			62: return '{seqInc, cmdSrm, regX8};
			63: return '{seqOp, cmdSx16r, regPc};
			64: return '{seqOp, cmdAddx16, regX8};
			65: return '{seqEof, cmdSpc, regX16};
			// JR NZ,n, falls through when Z is set
			66: return '{seqInc, cmdNop, regNull};
			67: return '{seqOp, cmdSma, regPc};
			68: return '{seqIncEofZ, cmdSrm, regX8};
			69: return '{seqOp, cmdSx16r, regPc};
			70: return '{seqOp, cmdAddx16, regX8};
			71: return '{seqEof, cmdSpc, regX16};
			// JR Z,n
			72: return '{seqInc, cmdNop, regNull};
			73: return '{seqOp, cmdSma, regPc};
			74: return '{seqIncEofNz, cmdSrm, regX8};
			75: return '{seqOp, cmdSx16r, regPc};
			76: return '{seqOp, cmdAddx16, regX8};
			77: return '{seqEof, cmdSpc, regX16};
			default: return uopIdle;
		endcase
	endfunction

	always_comb
	begin
		uop = romLookup(upc);
	end

	// Every populated slot must reach an end code within 12 steps
	initial
	begin : flowCheck
		int steps;
		logic [`DZ_UPC_W-1:0] addr;
		for (int s = 0; s < (1 << `DZ_UPC_W); s++)
		begin
			if (romLookup(s[`DZ_UPC_W-1:0]) != uopIdle)
			begin
				steps = 0;
				addr = s[`DZ_UPC_W-1:0];
				while (!isEof(romLookup(addr).seq) && steps < 12)
				begin
					addr = addr + 1'b1;
					steps++;
				end
				assert (steps < 12)
				else $error("ucode flow at %0d runs past 12 steps", s);
			end
		end
	end

endmodule

//--- dzcpu_bus_if.sv
`timescale 1ns/10ps
`include "dzcpu_defines.svh"

module dzcpu_bus_if
	import dzcpu_pkg::*;
(
	input  logic        Clock,
	input  logic        reset,
	input  uop_t        curUop,
	input  logic        fetchPending,
	input  logic [15:0] addrValue,
	input  logic [15:0] branchTarget,
	input  logic [7:0]  writeData,
	input  logic        readValid,
	input  memRead_t    readData,
	output logic        readStrobe,
	output memReq_t     readReq,
	output logic        writeStrobe,
	output memWrite_t   write,
	output logic [15:0] pc,
	output logic        fetchDone,
	output logic [7:0]  memData
);

	logic [15:0] mar;
	logic        rdOutstanding;
	// Outstanding read is an opcode fetch
	logic        fetchRead;
	logic        srmNow;
	logic        uopDone;

	//////////////////////////////////////////////////
	// Strobes and returned data
	//////////////////////////////////////////////////
	always_comb
	begin
		srmNow = (curUop.cmd == cmdSrm);
		// srm holds until its data shows up
		uopDone = !(srmNow && !readValid);
		readStrobe = !rdOutstanding && (fetchPending || srmNow);
		// Opcode reads use PC, operand reads the MAR
		readReq.addr = fetchPending ? pc : mar;
		fetchDone = readValid && fetchRead;
		memData = readData.data;
		writeStrobe = (curUop.cmd == cmdSmw);
		write.addr = mar;
		write.data = writeData;
	end

	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			pc <= `DZ_PC_RESET;
			rdOutstanding <= 1'b0;
			fetchRead <= 1'b0;
		end
		else
		begin
			if (readStrobe)
			begin
				rdOutstanding <= 1'b1;
				fetchRead <= fetchPending;
			end
			else if (readValid)
			begin
				rdOutstanding <= 1'b0;
			end
			// PC moves only when the micro-op completes
			if (uopDone)
			begin
				if (curUop.cmd == cmdSpc)
					pc <= branchTarget;
				else if (incsPc(curUop.seq))
					pc <= pc + 16'd1;
			end
		end
	end

	// Memory address register
	always_ff @(posedge Clock)
	begin
		if (curUop.cmd == cmdSma)
			mar <= addrValue;
	end

	// Issuer of an outstanding read holds until its answer
	assert property (@(posedge Clock) disable iff (reset)
		rdOutstanding |-> (fetchRead ? fetchPending : srmNow));

endmodule

//--- dzcpu_sequencer.sv
`timescale 1ns/10ps
`include "dzcpu_defines.svh"

module dzcpu_sequencer
	import dzcpu_pkg::*;
(
	input  logic     Clock,
	input  logic     reset,
	input  memRead_t readData,
	input  logic     fetchDone,
	input  logic     readValid,
	input  logic     zeroFlag,
	output uop_t     curUop,
	output logic     stall,
	output logic     fetchPending
);

	logic [7:0]           opcode;
	logic [7:0]           flowStart;
	// Offset inside the current flow
	logic [`DZ_UPC_W-1:0] step;
	logic [`DZ_UPC_W-1:0] upc;
	uop_t                 romUop;
	logic                 started;
	logic                 active;
	logic                 endNow;

	dzcpu_ucode_lut lut
	(
		.opcode    (opcode),
		.flowStart (flowStart)
	);

	dzcpu_ucode_rom rom
	(
		.upc (upc),
		.uop (romUop)
	);

	//////////////////////////////////////////////////
	// Micro-op issue
	//////////////////////////////////////////////////
	always_comb
	begin
		upc = flowStart + step;
		active = started && !fetchPending;
		// Idle while an opcode is on its way
		curUop = active ? romUop : uopIdle;
		stall = active && (romUop.cmd == cmdSrm) && !readValid;
		endNow = active && !stall &&
			(isEof(romUop.seq) ||
			(romUop.seq == seqIncEofZ && zeroFlag) ||
			(romUop.seq == seqIncEofNz && !zeroFlag));
	end

	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			started <= 1'b0;
			fetchPending <= 1'b0;
			step <= '0;
			opcode <= `OP_NOP;
		end
		else
		begin
			started <= 1'b1;
			if (!started)
				fetchPending <= 1'b1;
			else if (fetchDone)
			begin
				// New flow starts at offset zero
				opcode <= readData.data;
				step <= '0;
				fetchPending <= 1'b0;
			end
			else if (endNow)
				fetchPending <= 1'b1;
			else if (active && !stall)
				step <= step + 1'b1;
		end
	end

	// Read data releases the stall for good, flows never chain two srm
	assert property (@(posedge Clock) disable iff (reset)
		(active && romUop.cmd == cmdSrm && readValid) |=> !stall);

endmodule

//--- dzcpu_datapath.sv
`timescale 1ns/10ps

module dzcpu_datapath
	import dzcpu_pkg::*;
(
	input  logic        Clock,
	input  logic        reset,
	input  uop_t        curUop,
	input  logic        stall,
	input  logic [15:0] pc,
	input  logic [7:0]  memData,
	input  logic        readValid,
	output logic [15:0] addrValue,
	output logic [15:0] branchTarget,
	output logic [7:0]  writeData,
	output logic        zeroFlag
);

	// A, B, C, D, E, H, L in operand order
	logic [7:0]  regFile [7];
	logic [7:0]  x8;
	logic [15:0] x16;
	logic        zFlag;
	operand_t    opnd;
	logic        isReg8;
	logic        isPair;
	logic [7:0]  value8;
	logic [15:0] value16;
	logic [15:0] aluResult;
	logic [15:0] wbValue;
	logic        flagUpdate;

	//////////////////////////////////////////////////
	// Operand select
	//////////////////////////////////////////////////
	always_comb
	begin
		opnd = curUop.operand;
		isReg8 = (opnd <= regL);
		isPair = (opnd == regHl) || (opnd == regDe);
		if (isReg8)
			value8 = regFile[opnd[2:0]];
		else if (opnd == regX8)
			value8 = x8;
		else
			value8 = 8'h00;
	end

	always_comb
	begin
		case (opnd)
			regHl:   value16 = {regFile[5], regFile[6]};
			regDe:   value16 = {regFile[3], regFile[4]};
			regPc:   value16 = pc;
			regX16:  value16 = x16;
			default: value16 = {8'h00, value8};
		endcase
	end

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////
	always_comb
	begin
		case (curUop.cmd)
			cmdInc16:  aluResult = value16 + 16'd1;
			cmdDec16:  aluResult = value16 - 16'd1;
			// x8 is the signed jump offset
			cmdAddx16: aluResult = x16 + ((opnd == regX8) ?
				{{8{x8[7]}}, x8} : {8'h00, value8});
			cmdSubx16: aluResult = x16 - {8'h00, value8};
			default:   aluResult = value16;
		endcase
		wbValue = (curUop.cmd == cmdSrx16) ? x16 : aluResult;
		// Pair steps leave flags alone
		flagUpdate = !stall && !isPair &&
			(curUop.seq inside {seqUpdateFlags, seqEofFu, seqIncEofFu});
		addrValue = value16;
		branchTarget = x16;
		writeData = value8;
		zeroFlag = zFlag;
	end

	// Register file and scratch registers
	always_ff @(posedge Clock)
	begin
		if (curUop.cmd == cmdSrm)
		begin
			if (readValid && isReg8)
				regFile[opnd[2:0]] <= memData;
			else if (readValid && opnd == regX8)
				x8 <= memData;
		end
		else if (!stall)
		begin
			case (curUop.cmd)
				cmdInc16, cmdDec16, cmdSrx16:
				begin
					if (isReg8)
						regFile[opnd[2:0]] <= wbValue[7:0];
					else if (opnd == regHl)
						{regFile[5], regFile[6]} <= wbValue;
					else if (opnd == regDe)
						{regFile[3], regFile[4]} <= wbValue;
				end
				cmdSx16r:             x16 <= value16;
				cmdAddx16, cmdSubx16: x16 <= aluResult;
				default:              x16 <= x16;
			endcase
		end
	end

	// Z from the 8-bit result
	always_ff @(posedge Clock)
	begin
		if (reset)
			zFlag <= 1'b0;
		else if (flagUpdate)
			zFlag <= (aluResult[7:0] == 8'h00);
	end

	// Flag codes only ride on ALU micro-ops
	assert property (@(posedge Clock) disable iff (reset)
		(curUop.seq inside {seqUpdateFlags, seqEofFu, seqIncEofFu}) |->
			(curUop.cmd inside {cmdInc16, cmdDec16, cmdAddx16, cmdSubx16}));

endmodule

//--- dzcpu_top.sv
`timescale 1ns/10ps

module dzcpu_top
	import dzcpu_pkg::*;
(
	input  logic      Clock,
	input  logic      reset,
	output logic      readStrobe,
	output memReq_t   readReq,
	input  logic      readValid,
	input  memRead_t  readData,
	output logic      writeStrobe,
	output memWrite_t write
);

	uop_t        curUop;
	logic        stall;
	logic        fetchPending;
	logic        fetchDone;
	logic        zeroFlag;
	logic [15:0] pc;
	logic [15:0] addrValue;
	logic [15:0] branchTarget;
	logic [7:0]  writeData;
	logic [7:0]  memData;

	// Input side, memory bus and PC
	dzcpu_bus_if busIf
	(
		.Clock        (Clock),
		.reset        (reset),
		.curUop       (curUop),
		.fetchPending (fetchPending),
		.addrValue    (addrValue),
		.branchTarget (branchTarget),
		.writeData    (writeData),
		.readValid    (readValid),
		.readData     (readData),
		.readStrobe   (readStrobe),
		.readReq      (readReq),
		.writeStrobe  (writeStrobe),
		.write        (write),
		.pc           (pc),
		.fetchDone    (fetchDone),
		.memData      (memData)
	);

	// Flow control with LUT and ROM
	dzcpu_sequencer sequencer
	(
		.Clock        (Clock),
		.reset        (reset),
		.readData     (readData),
		.fetchDone    (fetchDone),
		.readValid    (readValid),
		.zeroFlag     (zeroFlag),
		.curUop       (curUop),
		.stall        (stall),
		.fetchPending (fetchPending)
	);

	dzcpu_datapath datapath
	(
		.Clock        (Clock),
		.reset        (reset),
		.curUop       (curUop),
		.stall        (stall),
		.pc           (pc),
		.memData      (memData),
		.readValid    (readValid),
		.addrValue    (addrValue),
		.branchTarget (branchTarget),
		.writeData    (writeData),
		.zeroFlag     (zeroFlag)
	);

endmodule

//--- dzcpu_tb.sv
`timescale 1ns/10ps

module dzcpu_tb
	import dzcpu_pkg::*;
();

	localparam int RawDepth = 256;
	localparam int ResetCycles = 4;
	localparam int CyclesPerRead = 6;
	localparam int MarginCycles = 200;
	localparam int SettleCycles = 20;

	logic      Clock;
	logic      reset;
	logic      readStrobe;
	memReq_t   readReq;
	logic      readValid;
	memRead_t  readData;
	logic      writeStrobe;
	memWrite_t write;

	// Memory image and raw test records
	logic [7:0]  mem [0:65535];
	logic [31:0] raw [0:RawDepth-1];
	memWrite_t   expWrites [$];
	int          expTests [$];
	int          readCount;
	int          errorCount;
	int          testErrors [0:15];
	int          testWrites [0:15];
	int          testsClean;
	int          testsDirty;
	logic        loaded;
	logic        allDone;
	logic [31:0] lfsr;

	dzcpu_top i_dzcpu_top
	(
		.Clock       (Clock),
		.reset       (reset),
		.readStrobe  (readStrobe),
		.readReq     (readReq),
		.readValid   (readValid),
		.readData    (readData),
		.writeStrobe (writeStrobe),
		.write       (write)
	);

	// 8 ns period
	initial Clock = 1'b0;
	always #4 Clock = ~Clock;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Galois LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h80200003;
		else
			return state >> 1;
	endfunction

	// Two bits per delay give 1 to 4 cycles
	task automatic pickDelay(output int cycles);
		logic [1:0] bits;
		for (int i = 0; i < 2; i++)
		begin
			lfsr = lfsrNext(lfsr);
			bits[i] = lfsr[0];
		end
		cycles = 1 + int'(bits);
	endtask

	function automatic string testName(input int testNum);
		case (testNum)
			1:       return "LD r,n and LD HL,nn";
			2:       return "INC/DEC wrap and JR Z";
			3:       return "ADD A,A / ADD A,B / SUB B";
			4:       return "LD (HL+),A";
			5:       return "JR loop on DEC B";
			6:       return "CP n and branch";
			default: return "unnamed";
		endcase
	endfunction

	task automatic checkWrite(input memWrite_t got, input memWrite_t expected,
		input int testNum);
		if (got !== expected)
		begin
			$display("[FAIL] %0d ns write: expected addr %h data %h, got addr %h data %h",
				$time, expected.addr, expected.data, got.addr, got.data);
			errorCount++;
			testErrors[testNum]++;
		end
	endtask

	task automatic reportTest(input int testNum);
		if (testErrors[testNum] == 0)
			testsClean++;
		else
			testsDirty++;
		$display("Test %0d (%s): %0d writes, %0d mismatches", testNum,
			testName(testNum), testWrites[testNum], testErrors[testNum]);
	endtask

	// Kind byte 00 image, 1N write of test N, 20 read count, FF end
	task automatic loadTestData();
		logic [31:0] rec;
		memWrite_t   w;
		int          i;
		logic        stop;
		// Fill from the whole address before the image lands
		for (int a = 0; a < 65536; a++)
			mem[a] = a[15:8] ^ a[7:0] ^ 8'h5A;
		$readmemh("dzcpu_testdata.txt", raw);
		readCount = 0;
		i = 0;
		stop = 1'b0;
		while (!stop && i < RawDepth)
		begin
			rec = raw[i];
			if ($isunknown(rec) || rec[31:24] == 8'hFF)
				stop = 1'b1;
			else
			begin
				case (rec[31:28])
					4'h0: mem[rec[23:8]] = rec[7:0];
					4'h1:
					begin
						w.addr = rec[23:8];
						w.data = rec[7:0];
						expWrites.push_back(w);
						expTests.push_back(int'(rec[27:24]));
					end
					4'h2: readCount = int'(rec[15:0]);
					default:
					begin
						$display("Test data entry %0d has an unknown kind: %h", i, rec);
						errorCount++;
					end
				endcase
				i++;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Memory model and write monitor
	//////////////////////////////////////////////////

	// One answer per strobe in order
	always
	begin : memoryModel
		logic [15:0] addr;
		int          delay;
		@(negedge Clock);
		if (!reset && readStrobe === 1'b1)
		begin
			addr = readReq.addr;
			pickDelay(delay);
			repeat (delay) @(posedge Clock);
			#1;
			readValid = 1'b1;
			readData.data = mem[addr];
			@(posedge Clock);
			#1;
			readValid = 1'b0;
			readData.data = 8'h00;
		end
	end

	always @(negedge Clock)
	begin : writeMonitor
		memWrite_t expected;
		int        testNum;
		if (!reset && writeStrobe === 1'b1)
		begin
			if (expWrites.size() == 0)
			begin
				$display("Unexpected write at %0d ns to %h with data %h, none left to expect",
					$time, write.addr, write.data);
				errorCount++;
			end
			else
			begin
				expected = expWrites.pop_front();
				testNum = expTests.pop_front();
				testWrites[testNum]++;
				checkWrite(write, expected, testNum);
				// Last record of this test
				if (expTests.size() == 0 || expTests[0] != testNum)
					reportTest(testNum);
				if (expWrites.size() == 0)
					allDone = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Watchdog and main sequence
	//////////////////////////////////////////////////
	initial
	begin : watchdog
		int limit;
		wait (loaded === 1'b1);
		limit = readCount * CyclesPerRead + MarginCycles;
		repeat (limit) @(posedge Clock);
		$display("Watchdog expired after %0d cycles, %0d expected writes never arrived",
			limit, expWrites.size());
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin : mainSequence
		reset = 1'b1;
		readValid = 1'b0;
		readData = '0;
		errorCount = 0;
		testsClean = 0;
		testsDirty = 0;
		allDone = 1'b0;
		loaded = 1'b0;
		lfsr = 32'hce091cb0;
		for (int t = 0; t < 16; t++)
		begin
			testErrors[t] = 0;
			testWrites[t] = 0;
		end
		loadTestData();
		loaded = 1'b1;
		if (expWrites.size() == 0)
		begin
			$display("Test data holds no expected writes");
			errorCount++;
			allDone = 1'b1;
		end
		repeat (ResetCycles) @(posedge Clock);
		#1;
		reset = 1'b0;
		wait (allDone === 1'b1);
		// Catch stray writes after the last one
		repeat (SettleCycles) @(posedge Clock);
		$display("Summary: %0d tests clean, %0d tests with errors, %0d errors in all",
			testsClean, testsDirty, errorCount);
		if (errorCount == 0 && testsDirty == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- dzcpu_testdata.txt
// One 32-bit record per word: kind byte, 16-bit address, data byte
// Kind 00 image byte, 1N expected write of test N, 20 read count, FF end
// Program image from 0000h
00000021 00000100 000002C0 0000033E 0000045A 00000577 00000626 000007C1
0000082E 00000923 00000A3E 00000BA5 00000C77 00000D3E 00000EFF 00000F3C
00001077 0000113D 0000122E 00001324 00001477 0000151E 00001601 0000171D
00001828 00001901 00001A77 00001B16 00001CFF 00001D14 00001E28 00001F01
00002077 0000210E 00002280 0000230D 00002428 00002501 0000263E 00002711
0000282C 00002977 00002A06 00002B7F 00002C3E 00002D61 00002E87 00002F2C
00003077 00003180 0000322C 00003377 00003490 0000352C 00003677 00003721
000038FE 000039C2 00003A3E 00003B31 00003C22 00003D3C 00003E22 00003F3C
00004022 0000413C 00004277 00004306 00004404 00004521 00004600 000047C4
0000483E 000049A0 00004A77 00004B2C 00004C3C 00004D05 00004E20 00004F02
00005018 00005102 00005218 000053F6 0000543E 00005542 000056FE 00005742
00005828 00005902 00005A3E 00005B99 00005C21 00005D00 00005EC5 00005F77
000060FE 00006117 00006220 00006302 0000643E 00006599 0000662C 00006777
000068FE 00006943 00006A28 00006B02 00006C3C 00006D00 00006E2C 00006F77
00007018 000071FE
// Expected writes, one line per test
11C0005A 11C123A5
12C12300 12C124FF 12C12511
13C126C2 13C12741 13C128C2
14C2FE31 14C2FF32 14C30033 14C30134
15C400A0 15C401A1 15C402A2 15C403A3
16C50042 16C50142 16C50243
// Program read count, then end
20000082 FFFFFFFF

//--- files.f
+incdir+.
dzcpu_pkg.sv
dzcpu_ucode_lut.sv
dzcpu_ucode_rom.sv
dzcpu_bus_if.sv
dzcpu_sequencer.sv
dzcpu_datapath.sv
dzcpu_top.sv
dzcpu_tb.sv

//--- Bender.yml
package:
  name: dzcpu

export_include_dirs:
  - .

sources:
  - files:
      - dzcpu_pkg.sv
      - dzcpu_ucode_lut.sv
      - dzcpu_ucode_rom.sv
      - dzcpu_bus_if.sv
      - dzcpu_sequencer.sv
      - dzcpu_datapath.sv
      - dzcpu_top.sv
  - target: test
    files:
      - dzcpu_tb.sv
